// File: hw/periph_hub_pkg.sv
// Shared definitions for the peripheral hub
//   word and address widths
//   bus request struct used by every master and the memory
//   copy engine register map and configuration write struct

package periph_hub_pkg;

  localparam int unsigned addr_w = 16;
  localparam int unsigned data_w = 32;

  typedef logic [addr_w-1:0] addr_t;
  typedef logic [data_w-1:0] data_t;

  // One bus transfer, held by the master until granted
  typedef struct packed {
    logic  valid;
    logic  we;     // Write when set
    addr_t addr;
    data_t wdata;
  } bus_req_t;

  // Copy engine register indices
  typedef enum logic [2:0] {
    REG_SRC    = 3'd0,
    REG_DST    = 3'd1,
    REG_LEN    = 3'd2,
    REG_CTRL   = 3'd3,  // Bit 0 starts a copy
    REG_STATUS = 3'd4   // Bit 0 done, bit 1 busy
  } cfg_reg_e;

  typedef struct packed {
    logic     we;
    cfg_reg_e addr;
    data_t    wdata;
  } cfg_req_t;

endpackage

// File: hw/bus_arbiter.sv
// Round-robin arbiter for the shared memory bus
//   one grant per cycle, forwarded to the memory port
//   read-valid routed back to the issuing master one cycle later

module bus_arbiter #(
  parameter int unsigned num_masters = 4,
  parameter int unsigned mem_words   = 256
) (
  input  logic                                       periph_clk,
  input  logic                                       reset_i,
  input  periph_hub_pkg::bus_req_t [num_masters-1:0] mst_req_i,
  input  periph_hub_pkg::data_t                      mem_rdata_i,
  output logic [num_masters-1:0]                     mst_gnt_o,
  output logic [num_masters-1:0]                     mst_rvalid_o,
  output periph_hub_pkg::data_t                      mst_rdata_o,
  output periph_hub_pkg::bus_req_t                   mem_req_o
);

  import periph_hub_pkg::*;

  localparam int unsigned idx_w = (num_masters > 1) ? $clog2(num_masters) : 1;
  localparam int unsigned aw = $clog2(mem_words);
  localparam addr_t addr_mask = addr_t'((32'd1 << aw) - 1);

  logic [idx_w-1:0] ptr_q;      // Highest priority master
  logic [idx_w-1:0] gnt_idx;
  logic             gnt_valid;
  logic             rd_pend_q;
  logic [idx_w-1:0] rd_idx_q;   // Issuer of the read in flight
  bus_req_t         sel_req;

  //////////////////////////////////////////////////////////////////////
  // Request selection
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    int unsigned cand;
    gnt_valid = 1'b0;
    gnt_idx   = ptr_q;
    for (int unsigned i = 0; i < num_masters; i++) begin
      cand = ptr_q + i;
      if (cand >= num_masters) cand = cand - num_masters;
      if (!gnt_valid && mst_req_i[cand].valid) begin
        gnt_valid = 1'b1;
        gnt_idx   = idx_w'(cand);
      end
    end
  end

  assign sel_req = mst_req_i[gnt_idx];

  always_comb begin
    mem_req_o = '0;
    mst_gnt_o = '0;
    if (gnt_valid) begin
      mem_req_o      = sel_req;
      mem_req_o.addr = sel_req.addr & addr_mask;  // Wrap to memory depth
      mst_gnt_o[gnt_idx] = 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Pointer and read return
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge periph_clk) begin
    if (reset_i) begin
      ptr_q     <= '0;
      rd_pend_q <= 1'b0;
    end else begin
      if (gnt_valid) begin
        ptr_q <= (gnt_idx == idx_w'(num_masters - 1)) ? '0 : gnt_idx + 1'b1;
      end
      rd_pend_q <= gnt_valid && !sel_req.we;
    end
  end

  always_ff @(posedge periph_clk) begin
    if (gnt_valid) rd_idx_q <= gnt_idx;
  end

  always_comb begin
    mst_rvalid_o = '0;
    if (rd_pend_q) mst_rvalid_o[rd_idx_q] = 1'b1;
  end

  assign mst_rdata_o = mem_rdata_i;  // Shared by all masters

endmodule

// File: hw/shared_sram.sv
// Shared single-port word memory
//   write on a valid write request
//   registered read data, one cycle after the request

module shared_sram #(
  parameter int unsigned mem_words = 256
) (
  input  logic                     periph_clk,
  input  periph_hub_pkg::bus_req_t mem_req_i,
  output periph_hub_pkg::data_t    mem_rdata_o
);

  import periph_hub_pkg::*;

  localparam int unsigned aw = $clog2(mem_words);

  data_t         mem_q [mem_words];
  data_t         rdata_q;
  logic [aw-1:0] word_idx;

  assign word_idx = mem_req_i.addr[aw-1:0];  // Low bits only

  always_ff @(posedge periph_clk) begin
    if (mem_req_i.valid) begin
      if (mem_req_i.we) begin
        mem_q[word_idx] <= mem_req_i.wdata;
      end else begin
        rdata_q <= mem_q[word_idx];
      end
    end
  end

  // Holds the last read word until the next read
  assign mem_rdata_o = rdata_q;

endmodule

// File: hw/copy_dma.sv
// Register-programmed copy engine
//   source, destination, length and status registers
//   combinational register readback
//   FSM issuing one read and one write per copied word

module copy_dma (
  input  logic                     periph_clk,
  input  logic                     reset_i,
  input  periph_hub_pkg::cfg_req_t cfg_req_i,
  input  logic                     bus_gnt_i,
  input  logic                     bus_rvalid_i,
  input  periph_hub_pkg::data_t    bus_rdata_i,
  output periph_hub_pkg::data_t    cfg_rdata_o,
  output periph_hub_pkg::bus_req_t bus_req_o,
  output logic                     done_o
);

  import periph_hub_pkg::*;

  typedef enum logic [2:0] {
    st_idle,
    st_read,
    st_wait,
    st_write,
    st_finish
  } state_e;

  state_e state_q;
  addr_t  src_q;
  addr_t  dst_q;
  addr_t  len_q;
  addr_t  offset_q;   // Index of the word being copied
  data_t  data_q;     // Word between read and write
  logic   done_q;
  logic   busy_q;
  logic   start;
  logic   last_word;

  //////////////////////////////////////////////////////////////////////
  // Configuration registers
  //////////////////////////////////////////////////////////////////////

  assign start = cfg_req_i.we && (cfg_req_i.addr == REG_CTRL) &&
                 cfg_req_i.wdata[0] && (state_q == st_idle);

  always_ff @(posedge periph_clk) begin
    if (reset_i) begin
      src_q <= '0;
      dst_q <= '0;
      len_q <= '0;
    end else if (cfg_req_i.we) begin
      case (cfg_req_i.addr)
        REG_SRC: src_q <= cfg_req_i.wdata[addr_w-1:0];
        REG_DST: dst_q <= cfg_req_i.wdata[addr_w-1:0];
        REG_LEN: len_q <= cfg_req_i.wdata[addr_w-1:0];
        default: ;
      endcase
    end
  end

  always_comb begin
    case (cfg_req_i.addr)
      REG_SRC:    cfg_rdata_o = data_t'(src_q);
      REG_DST:    cfg_rdata_o = data_t'(dst_q);
      REG_LEN:    cfg_rdata_o = data_t'(len_q);
      REG_STATUS: cfg_rdata_o = data_t'({busy_q, done_q});
      default:    cfg_rdata_o = '0;  // CTRL is write only
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Copy FSM
  //////////////////////////////////////////////////////////////////////

  assign last_word = (offset_q + 1'b1) == len_q;

  always_ff @(posedge periph_clk) begin
    if (reset_i) begin
      state_q  <= st_idle;
      offset_q <= '0;
      done_q   <= 1'b0;
      busy_q   <= 1'b0;
    end else begin
      case (state_q)
        st_idle: begin
          if (start) begin
            done_q   <= 1'b0;
            busy_q   <= 1'b1;
            offset_q <= '0;
            state_q  <= (len_q == '0) ? st_finish : st_read;
          end
        end
        st_read: begin
          if (bus_gnt_i) state_q <= st_wait;
        end
        st_wait: begin
          if (bus_rvalid_i) state_q <= st_write;
        end
        st_write: begin
          if (bus_gnt_i) begin
            offset_q <= offset_q + 1'b1;
            state_q  <= last_word ? st_finish : st_read;
          end
        end
        st_finish: begin
          done_q  <= 1'b1;   // Busy drops with it
          busy_q  <= 1'b0;
          state_q <= st_idle;
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  always_ff @(posedge periph_clk) begin
    if (state_q == st_wait && bus_rvalid_i) data_q <= bus_rdata_i;
  end

  // Bus port
  always_comb begin
    bus_req_o = '0;
    case (state_q)
      st_read: begin
        bus_req_o.valid = 1'b1;
        bus_req_o.addr  = src_q + offset_q;
      end
      st_write: begin
        bus_req_o.valid = 1'b1;
        bus_req_o.we    = 1'b1;
        bus_req_o.addr  = dst_q + offset_q;
        bus_req_o.wdata = data_q;
      end
      default: ;
    endcase
  end

  assign done_o = done_q;

endmodule

// File: hw/periph_hub.sv
// Peripheral hub top level
//   external bus ports and the copy engine share one arbiter
//   arbiter drives the shared word memory

module periph_hub #(
  parameter int unsigned num_ext_ports = 3,
  parameter int unsigned mem_words     = 256
) (
  input  logic                                         periph_clk,
  input  logic                                         reset_i,
  input  periph_hub_pkg::bus_req_t [num_ext_ports-1:0] ext_req_i,
  input  periph_hub_pkg::cfg_req_t                     cfg_req_i,
  output logic [num_ext_ports-1:0]                     ext_gnt_o,
  output logic [num_ext_ports-1:0]                     ext_rvalid_o,
  output periph_hub_pkg::data_t                        ext_rdata_o,
  output periph_hub_pkg::data_t                        cfg_rdata_o,
  output logic                                         dma_done_o
);

  import periph_hub_pkg::*;

  localparam int unsigned num_masters = num_ext_ports + 1;

  bus_req_t [num_masters-1:0] mst_req;
  logic [num_masters-1:0]     mst_gnt;
  logic [num_masters-1:0]     mst_rvalid;
  data_t                      mst_rdata;
  bus_req_t                   dma_req;
  bus_req_t                   mem_req;
  data_t                      mem_rdata;

  // Copy engine sits at the top index
  assign mst_req      = {dma_req, ext_req_i};
  assign ext_gnt_o    = mst_gnt[num_ext_ports-1:0];
  assign ext_rvalid_o = mst_rvalid[num_ext_ports-1:0];
  assign ext_rdata_o  = mst_rdata;

  bus_arbiter #(
    .num_masters  ( num_masters ),
    .mem_words    ( mem_words   )
  ) bus_arbiter_i (
    .periph_clk   ( periph_clk ),
    .reset_i      ( reset_i    ),
    .mst_req_i    ( mst_req    ),
    .mem_rdata_i  ( mem_rdata  ),
    .mst_gnt_o    ( mst_gnt    ),
    .mst_rvalid_o ( mst_rvalid ),
    .mst_rdata_o  ( mst_rdata  ),
    .mem_req_o    ( mem_req    )
  );

  shared_sram #(
    .mem_words    ( mem_words )
  ) shared_sram_i (
    .periph_clk   ( periph_clk ),
    .mem_req_i    ( mem_req    ),
    .mem_rdata_o  ( mem_rdata  )
  );

  copy_dma copy_dma_i (
    .periph_clk   ( periph_clk                 ),
    .reset_i      ( reset_i                    ),
    .cfg_req_i    ( cfg_req_i                  ),
    .bus_gnt_i    ( mst_gnt[num_ext_ports]     ),
    .bus_rvalid_i ( mst_rvalid[num_ext_ports]  ),
    .bus_rdata_i  ( mst_rdata                  ),
    .cfg_rdata_o  ( cfg_rdata_o                ),
    .bus_req_o    ( dma_req                    ),
    .done_o       ( dma_done_o                 )
  );

endmodule

// File: tests/periph_hub_asserts.sv
// Concurrent checks on the arbiter handshake
//   grants one-hot or zero, only to valid requests
//   read grant answered by that master's read-valid one cycle later

module periph_hub_asserts #(
  parameter int unsigned num_masters = 4
) (
  input logic                                       periph_clk,
  input logic                                       reset_i,
  input periph_hub_pkg::bus_req_t [num_masters-1:0] mst_req_i,
  input logic [num_masters-1:0]                     mst_gnt_o,
  input logic [num_masters-1:0]                     mst_rvalid_o
);

  logic [num_masters-1:0] req_valid;
  logic [num_masters-1:0] rd_gnt;  // Grants that start a read

  always_comb begin
    for (int i = 0; i < num_masters; i++) begin
      req_valid[i] = mst_req_i[i].valid;
      rd_gnt[i]    = mst_gnt_o[i] && !mst_req_i[i].we;
    end
  end

  gnt_onehot: assert property (@(posedge periph_clk) disable iff (reset_i)
    $onehot0(mst_gnt_o)) else $error("Grant vector not one-hot");

  gnt_to_valid: assert property (@(posedge periph_clk) disable iff (reset_i)
    (mst_gnt_o & ~req_valid) == '0) else $error("Grant to an idle master");

  rd_return: assert property (@(posedge periph_clk) disable iff (reset_i)
    |rd_gnt |=> mst_rvalid_o == $past(rd_gnt)) else $error("Read-valid misrouted");

endmodule

bind bus_arbiter periph_hub_asserts #(
  .num_masters  ( num_masters )
) periph_hub_asserts_i (
  .periph_clk   ( periph_clk   ),
  .reset_i      ( reset_i      ),
  .mst_req_i    ( mst_req_i    ),
  .mst_gnt_o    ( mst_gnt_o    ),
  .mst_rvalid_o ( mst_rvalid_o )
);

// File: tests/periph_hub_tb.sv
// Testbench for the peripheral hub
//   clock, reset and random bus traffic on the external ports
//   reference memory model checked on every read return
//   fairness under full load, copy engine runs with and without traffic

module periph_hub_tb;

  import periph_hub_pkg::*;

  localparam int n_ports   = 3;
  localparam int mem_words = 256;
  localparam int n_single  = 8;    // Writes in the single port test
  localparam int n_mixed   = 12;   // Ops per port under concurrent traffic
  localparam int n_fair    = 60;   // Cycles of full load
  localparam int max_len   = 16;
  localparam int n_bus_ops = 2 * n_single + 6 * n_mixed + n_fair + 4 * max_len + 10;
  localparam int timeout_cycles = 40 * n_bus_ops + 2000 * 2;

  logic                   periph_clk;
  logic                   reset_i;
  bus_req_t [n_ports-1:0] ext_req;
  cfg_req_t               cfg_req;
  logic [n_ports-1:0]     ext_gnt;
  logic [n_ports-1:0]     ext_rvalid;
  data_t                  ext_rdata;
  data_t                  cfg_rdata;
  logic                   dma_done;

  integer             seed;
  data_t              model [int];  // Expected word per address
  logic [n_ports-1:0] rd_pend;
  logic [n_ports-1:0] rd_known;
  data_t              rd_exp [n_ports];
  int                 fair_gap [n_ports];
  bit                 fair_chk;
  int                 dma_writes;
  int                 errors;
  int                 checks;
  int                 tests;
  int                 cycles;

  periph_hub #(
    .num_ext_ports ( n_ports   ),
    .mem_words     ( mem_words )
  ) periph_hub_i (
    .periph_clk    ( periph_clk ),
    .reset_i       ( reset_i    ),
    .ext_req_i     ( ext_req    ),
    .cfg_req_i     ( cfg_req    ),
    .ext_gnt_o     ( ext_gnt    ),
    .ext_rvalid_o  ( ext_rvalid ),
    .ext_rdata_o   ( ext_rdata  ),
    .cfg_rdata_o   ( cfg_rdata  ),
    .dma_done_o    ( dma_done   )
  );

  initial begin
    periph_clk = 1'b0;
    forever #50 periph_clk = ~periph_clk;
  end

  always @(posedge periph_clk) begin
    cycles++;
    if (cycles >= timeout_cycles) begin
      $display("Run timed out after %0d cycles, a request or copy never completed", cycles);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  function automatic void expect_true(input bit ok, input string msg);
    checks++;
    assert (ok) else begin
      $display("CHECK FAILED at %0t: %s", $time, msg);
      errors++;
    end
  endfunction

  ////////////////////////////////////////////////////////////////////
  // Bus monitor and reference model
  ////////////////////////////////////////////////////////////////////

  always @(negedge periph_clk) begin
    int a;
    if (!reset_i) begin
      // Memory write with no external grant comes from the copy engine
      if (periph_hub_i.mem_req.valid && periph_hub_i.mem_req.we && ext_gnt == '0) dma_writes++;
      for (int p = 0; p < n_ports; p++) begin
        if (ext_rvalid[p]) begin
          expect_true(rd_pend[p], $sformatf("read-valid without a read on port %0d", p));
          if (rd_known[p]) expect_true(ext_rdata === rd_exp[p],
            $sformatf("port %0d read %h, expected %h", p, ext_rdata, rd_exp[p]));
          rd_pend[p] = 1'b0;
        end
        if (ext_gnt[p]) begin
          a = int'(ext_req[p].addr) % mem_words;
          if (ext_req[p].we) begin
            model[a] = ext_req[p].wdata;
          end else begin
            rd_pend[p]  = 1'b1;
            rd_known[p] = model.exists(a);
            if (rd_known[p]) rd_exp[p] = model[a];
          end
        end
        if (fair_chk && |ext_gnt) begin
          fair_gap[p]++;  // Grant cycles since this port's last grant
          expect_true(fair_gap[p] <= n_ports + 1,
            $sformatf("port %0d waited %0d grant cycles", p, fair_gap[p]));
          if (ext_gnt[p]) fair_gap[p] = 0;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Stimulus tasks, all called 10 units after a rising edge
  ////////////////////////////////////////////////////////////////////

  task automatic bus_op(input int p, input bit we, input addr_t a, input data_t d);
    ext_req[p] = '{valid: 1'b1, we: we, addr: a, wdata: d};
    do @(negedge periph_clk); while (!ext_gnt[p]);
    @(posedge periph_clk);
    #10;
    ext_req[p] = '0;
  endtask

  task automatic port_sweep(input int p, input bit we, input addr_t base, input int n);
    for (int i = 0; i < n; i++) bus_op(p, we, base + addr_t'(i), $random(seed));
  endtask

  // Random reads and writes inside the port's own 64-word window
  task automatic port_traffic(input int p, input int n);
    addr_t a;
    for (int i = 0; i < n; i++) begin
      a = addr_t'(p * 64 + $unsigned($random(seed)) % 64);
      bus_op(p, $random(seed) & 1, a, $random(seed));
    end
  endtask

  task automatic cfg_write(input cfg_reg_e r, input data_t d);
    cfg_req = '{we: 1'b1, addr: r, wdata: d};
    @(posedge periph_clk);
    #10;
    cfg_req = '{we: 1'b0, addr: REG_STATUS, wdata: '0};
  endtask

  task automatic run_copy(input addr_t src, input addr_t dst, input int len, input bit again);
    cfg_write(REG_SRC, data_t'(src));
    cfg_write(REG_DST, data_t'(dst));
    cfg_write(REG_LEN, data_t'(len));
    dma_writes = 0;
    cfg_write(REG_CTRL, 32'd1);
    if (again) begin
      while (dma_writes == 0) @(negedge periph_clk);
      @(posedge periph_clk);
      #10;
      cfg_write(REG_CTRL, 32'd1);  // Lands mid-copy
    end
    while (!dma_done) @(negedge periph_clk);
    expect_true(cfg_rdata[1:0] == 2'b01, $sformatf("status %h at copy end", cfg_rdata));
    @(posedge periph_clk);
    #10;
    expect_true(dma_writes == len, $sformatf("copy wrote %0d of %0d words", dma_writes, len));
    for (int i = 0; i < len; i++) model[(dst + i) % mem_words] = model[(src + i) % mem_words];
  endtask

  task automatic finish_test(input string name);
    repeat (3) @(negedge periph_clk);
    expect_true(rd_pend == '0, $sformatf("%s left a read unanswered", name));
    tests++;
    $display("Test %0d (%s) finished, %0d errors so far", tests, name, errors);
    @(posedge periph_clk);
    #10;
  endtask

  initial begin
    addr_t addrs [n_single];
    addr_t src;
    addr_t dst;
    int    len;
    seed = 32'h2640b64b;
    {errors, checks, tests, cycles, dma_writes} = '0;
    {rd_pend, rd_known, fair_chk} = '0;
    reset_i = 1'b1;
    ext_req = '0;
    cfg_req = '{we: 1'b0, addr: REG_STATUS, wdata: '0};
    repeat (3) @(posedge periph_clk);
    #10;
    reset_i = 1'b0;

    @(negedge periph_clk);
    expect_true(ext_gnt == '0 && ext_rvalid == '0, "grant or read-valid set after reset");
    expect_true(!dma_done && cfg_rdata == '0, "copy status not clear after reset");
    @(posedge periph_clk);
    #10;
    finish_test("reset state");

    for (int i = 0; i < n_single; i++) begin
      addrs[i] = addr_t'($random(seed));
      bus_op(0, 1'b1, addrs[i], $random(seed));
    end
    for (int i = 0; i < n_single; i++) bus_op(0, 1'b0, addrs[i], '0);
    finish_test("single port");

    fork
      port_traffic(0, n_mixed);
      port_traffic(1, n_mixed);
      port_traffic(2, n_mixed);
    join
    finish_test("concurrent ports");

    for (int p = 0; p < n_ports; p++) begin
      ext_req[p] = '{valid: 1'b1, we: 1'b1, wdata: $random(seed),
                     addr: addr_t'(p * 64 + $unsigned($random(seed)) % 64)};
      fair_gap[p] = 0;
    end
    fair_chk = 1'b1;
    repeat (n_fair) @(posedge periph_clk);
    #10;
    ext_req  = '0;
    fair_chk = 1'b0;
    finish_test("fairness");

    // Source window 192..214, destination window 224..246
    src = addr_t'(192 + $unsigned($random(seed)) % 8);
    dst = addr_t'(224 + $unsigned($random(seed)) % 8);
    len = 1 + $unsigned($random(seed)) % max_len;
    port_sweep(0, 1'b1, src, len);
    run_copy(src, dst, len, 1'b0);
    port_sweep(0, 1'b0, dst, len);
    finish_test("copy");

    src = addr_t'(192 + $unsigned($random(seed)) % 8);
    dst = addr_t'(224 + $unsigned($random(seed)) % 8);
    len = 2 + $unsigned($random(seed)) % (max_len - 1);
    port_sweep(0, 1'b1, src, len);
    fork
      run_copy(src, dst, len, 1'b1);
      port_traffic(0, n_mixed);
      port_traffic(1, n_mixed);
      port_traffic(2, n_mixed);
    join
    port_sweep(0, 1'b0, dst, len);
    finish_test("copy under traffic");

    $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: vlog.f
hw/periph_hub_pkg.sv
hw/bus_arbiter.sv
hw/shared_sram.sv
hw/copy_dma.sv
hw/periph_hub.sv
tests/periph_hub_asserts.sv
tests/periph_hub_tb.sv
